// File: design/mm_ram_pkg.sv
// Memory-mapped RAM definitions
`default_nettype none

package mm_ram_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------

    // Address and data width of both core ports
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;

    // One enable per data byte
    localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

    // Byte address bits covered by the RAM
    localparam int unsigned RAM_ADDR_WIDTH = 12;
    localparam int unsigned RAM_BYTES      = 2 ** RAM_ADDR_WIDTH;

    // Width of the debug request cycle counter
    localparam int unsigned DBG_CNT_WIDTH = 8;

    // --------------------------------------------------
    // Address map of the virtual peripherals
    // --------------------------------------------------

    localparam logic [ADDR_WIDTH-1:0] PRINT_ADDR  = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] DEBUG_ADDR  = 32'h1500_0000;
    localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR = 32'h2000_0000;
    localparam logic [ADDR_WIDTH-1:0] EXIT_ADDR   = 32'h2000_0004;

    // Codes recognized by the test-status register
    localparam logic [DATA_WIDTH-1:0] PASS_CODE = 32'd123456789;
    localparam logic [DATA_WIDTH-1:0] FAIL_CODE = 32'd1;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    // Target of one data access
    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_PRINT,
        REGION_STATUS,
        REGION_EXIT,
        REGION_DEBUG,
        REGION_NONE
    } region_e;

    // Debug request counter state
    typedef enum logic {
        DBG_IDLE,
        DBG_ACTIVE
    } dbg_state_e;

endpackage

`default_nettype wire

// File: design/mem_bus_if.sv
// Decoded data access bus
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import mm_ram_pkg::*; ();

    // Request strobe, one access per cycle
    logic                  req;
    // Full byte address
    logic [ADDR_WIDTH-1:0] addr;
    // High for a write
    logic                  we;
    // Byte lanes of a write
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
    // Read data, returned one cycle after req
    logic [DATA_WIDTH-1:0] rdata;

    // Memory or peripheral side
    modport target (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output rdata
    );

    // Router side
    modport initiator (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  rdata
    );

endinterface

`default_nettype wire

// File: design/dp_ram.sv
// Dual-port byte RAM
`timescale 1ns/1ps
`default_nettype none

module dp_ram import mm_ram_pkg::*; (
    input  wire logic                  clk_i,

    // Instruction read port
    input  wire logic                  instr_req_i,
    input  wire logic [ADDR_WIDTH-1:0] instr_addr_i,
    output      logic [DATA_WIDTH-1:0] instr_rdata_o,

    // Data read/write port
    mem_bus_if.target                  bus_if
);

    // Byte storage, little endian within a word
    logic [7:0] mem [0:RAM_BYTES-1];

    // Word aligned base addresses
    logic [RAM_ADDR_WIDTH-1:0] instr_base;
    logic [RAM_ADDR_WIDTH-1:0] data_base;

    // Registered read data
    logic [DATA_WIDTH-1:0] instr_rdata_q;
    logic [DATA_WIDTH-1:0] data_rdata_q;

    // Low two bits dropped
    assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};
    assign data_base  = {bus_if.addr[RAM_ADDR_WIDTH-1:2], 2'b00};

    // --------------------------------------------------
    // Instruction port
    // --------------------------------------------------

    // Sees the old word on a same-cycle data write
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < BE_WIDTH; i++) begin
                instr_rdata_q[8*i +: 8] <= mem[instr_base + i];
            end
        end
    end

    assign instr_rdata_o = instr_rdata_q;

    // --------------------------------------------------
    // Data port
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (bus_if.req) begin
            if (bus_if.we) begin
                // Only enabled byte lanes change
                for (int i = 0; i < BE_WIDTH; i++) begin
                    if (bus_if.be[i]) begin
                        mem[data_base + i] <= bus_if.wdata[8*i +: 8];
                    end
                end
            end else begin
                // Full word read, the core picks its lanes
                for (int i = 0; i < BE_WIDTH; i++) begin
                    data_rdata_q[8*i +: 8] <= mem[data_base + i];
                end
            end
        end
    end

    assign bus_if.rdata = data_rdata_q;

endmodule

`default_nettype wire

// File: design/data_router.sv
// Data port address router
`timescale 1ns/1ps
`default_nettype none

module data_router import mm_ram_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Data port from the core
    input  wire logic                  data_req_i,
    input  wire logic [ADDR_WIDTH-1:0] data_addr_i,
    input  wire logic                  data_we_i,
    input  wire logic [BE_WIDTH-1:0]   data_be_i,
    input  wire logic [DATA_WIDTH-1:0] data_wdata_i,
    output      logic                  data_gnt_o,
    output      logic                  data_rvalid_o,
    output      logic [DATA_WIDTH-1:0] data_rdata_o,

    // Region of the access in this cycle
    output      region_e               region_o,

    // Steered buses
    mem_bus_if.initiator               ram_bus,
    mem_bus_if.initiator               periph_bus
);

    region_e region;
    region_e region_q;
    logic    rvalid_q;
    logic    is_periph;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    always_comb begin
        if (data_addr_i < RAM_BYTES) begin
            region = REGION_RAM;
        end else if (data_addr_i == PRINT_ADDR) begin
            region = REGION_PRINT;
        end else if (data_addr_i == STATUS_ADDR) begin
            region = REGION_STATUS;
        end else if (data_addr_i == EXIT_ADDR) begin
            region = REGION_EXIT;
        end else if (data_addr_i == DEBUG_ADDR) begin
            region = REGION_DEBUG;
        end else begin
            region = REGION_NONE;
        end
    end

    assign is_periph = (region != REGION_RAM) && (region != REGION_NONE);
    assign region_o  = region;

    // RAM never stalls
    assign data_gnt_o = data_req_i;

    // --------------------------------------------------
    // Request steering
    // --------------------------------------------------

    // Unmapped accesses reach neither bus
    assign ram_bus.req   = data_req_i && (region == REGION_RAM);
    assign ram_bus.addr  = data_addr_i;
    assign ram_bus.we    = data_we_i;
    assign ram_bus.be    = data_be_i;
    assign ram_bus.wdata = data_wdata_i;

    assign periph_bus.req   = data_req_i && is_periph;
    assign periph_bus.addr  = data_addr_i;
    assign periph_bus.we    = data_we_i;
    assign periph_bus.be    = data_be_i;
    assign periph_bus.wdata = data_wdata_i;

    // --------------------------------------------------
    // Response
    // --------------------------------------------------

    // Region kept for the rdata mux in the next cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            region_q <= REGION_NONE;
        end else begin
            rvalid_q <= data_req_i;
            if (data_req_i) begin
                region_q <= region;
            end
        end
    end

    assign data_rvalid_o = rvalid_q;

    always_comb begin
        case (region_q)
            REGION_RAM:  data_rdata_o = ram_bus.rdata;
            REGION_NONE: data_rdata_o = '0;
            default:     data_rdata_o = periph_bus.rdata;
        endcase
    end

endmodule

`default_nettype wire

// File: design/virt_periph.sv
// Virtual peripherals
`timescale 1ns/1ps
`default_nettype none

module virt_periph import mm_ram_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Decoded access from the router
    input  wire region_e               region_i,
    mem_bus_if.target                  bus_if,

    // Character output
    output      logic                  print_valid_o,
    output      logic [7:0]            print_char_o,

    // Test status and exit
    output      logic                  tests_passed_o,
    output      logic                  tests_failed_o,
    output      logic                  exit_valid_o,
    output      logic [DATA_WIDTH-1:0] exit_value_o,

    // Debug request line to the core
    output      logic                  debug_req_o
);

    logic wr_en;

    logic                     print_valid_q;
    logic [7:0]               print_char_q;
    logic                     passed_q;
    logic                     failed_q;
    logic                     exit_valid_q;
    logic [DATA_WIDTH-1:0]    exit_value_q;

    dbg_state_e               dbg_state_q;
    logic [DBG_CNT_WIDTH-1:0] dbg_cnt_q;
    logic [DBG_CNT_WIDTH-1:0] dbg_len;

    // Byte enables play no part here
    assign wr_en = bus_if.req && bus_if.we;

    // Reads of any peripheral give zero
    assign bus_if.rdata = '0;

    // --------------------------------------------------
    // Pulses and exit value
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            print_valid_q <= 1'b0;
            passed_q      <= 1'b0;
            failed_q      <= 1'b0;
            exit_valid_q  <= 1'b0;
            exit_value_q  <= '0;
        end else begin
            print_valid_q <= wr_en && (region_i == REGION_PRINT);
            // Other status codes fall through as no event
            passed_q      <= wr_en && (region_i == REGION_STATUS) &&
                             (bus_if.wdata == PASS_CODE);
            failed_q      <= wr_en && (region_i == REGION_STATUS) &&
                             (bus_if.wdata == FAIL_CODE);
            exit_valid_q  <= wr_en && (region_i == REGION_EXIT);
            // Exit code holds until the next exit write
            if (wr_en && (region_i == REGION_EXIT)) begin
                exit_value_q <= bus_if.wdata;
            end
        end
    end

    // Character byte
    always_ff @(posedge clk_i) begin
        if (wr_en && (region_i == REGION_PRINT)) begin
            print_char_q <= bus_if.wdata[7:0];
        end
    end

    assign print_valid_o  = print_valid_q;
    assign print_char_o   = print_char_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

    // --------------------------------------------------
    // Debug request counter
    // --------------------------------------------------

    // Requested cycle count from the low byte
    assign dbg_len = bus_if.wdata[DBG_CNT_WIDTH-1:0];

    // Counter holds cycles left after the current one
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dbg_state_q <= DBG_IDLE;
            dbg_cnt_q   <= '0;
        end else if (wr_en && (region_i == REGION_DEBUG)) begin
            // A new write restarts, zero stops the request
            if (dbg_len != '0) begin
                dbg_state_q <= DBG_ACTIVE;
                dbg_cnt_q   <= dbg_len - 1'b1;
            end else begin
                dbg_state_q <= DBG_IDLE;
                dbg_cnt_q   <= '0;
            end
        end else if (dbg_state_q == DBG_ACTIVE) begin
            if (dbg_cnt_q == '0) begin
                dbg_state_q <= DBG_IDLE;
            end else begin
                dbg_cnt_q <= dbg_cnt_q - 1'b1;
            end
        end
    end

    assign debug_req_o = (dbg_state_q == DBG_ACTIVE);

endmodule

`default_nettype wire

// File: design/mm_ram.sv
// Memory-mapped RAM top level
`timescale 1ns/1ps
`default_nettype none

module mm_ram import mm_ram_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Instruction port
    input  wire logic                  instr_req_i,
    input  wire logic [ADDR_WIDTH-1:0] instr_addr_i,
    output      logic                  instr_gnt_o,
    output      logic                  instr_rvalid_o,
    output      logic [DATA_WIDTH-1:0] instr_rdata_o,

    // Data port
    input  wire logic                  data_req_i,
    input  wire logic [ADDR_WIDTH-1:0] data_addr_i,
    input  wire logic                  data_we_i,
    input  wire logic [BE_WIDTH-1:0]   data_be_i,
    input  wire logic [DATA_WIDTH-1:0] data_wdata_i,
    output      logic                  data_gnt_o,
    output      logic                  data_rvalid_o,
    output      logic [DATA_WIDTH-1:0] data_rdata_o,

    // Virtual peripheral outputs
    output      logic                  print_valid_o,
    output      logic [7:0]            print_char_o,
    output      logic                  tests_passed_o,
    output      logic                  tests_failed_o,
    output      logic                  exit_valid_o,
    output      logic [DATA_WIDTH-1:0] exit_value_o,
    output      logic                  debug_req_o
);

    region_e region;
    logic    instr_rvalid_q;

    mem_bus_if ram_bus ();
    mem_bus_if periph_bus ();

    // --------------------------------------------------
    // Instruction handshake
    // --------------------------------------------------

    // Always granted
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;

    // --------------------------------------------------
    // Storage, routing and peripherals
    // --------------------------------------------------

    dp_ram dp_ram_i (
        .clk_i         (clk_i),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_rdata_o (instr_rdata_o),
        .bus_if        (ram_bus)
    );

    data_router data_router_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_we_i     (data_we_i),
        .data_be_i     (data_be_i),
        .data_wdata_i  (data_wdata_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .region_o      (region),
        .ram_bus       (ram_bus),
        .periph_bus    (periph_bus)
    );

    virt_periph virt_periph_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .region_i       (region),
        .bus_if         (periph_bus),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .debug_req_o    (debug_req_o)
    );

endmodule

`default_nettype wire

// File: tests/mm_ram_assertions.sv
// Handshake and peripheral assertions
`timescale 1ns/1ps
`default_nettype none

module mm_ram_assertions import mm_ram_pkg::*; (
    input wire logic       clk_i,
    input wire logic       rst_n_i,
    input wire logic       instr_req_i,
    input wire logic       instr_rvalid_i,
    input wire logic       data_req_i,
    input wire logic       data_rvalid_i,
    input wire logic       print_valid_i,
    input wire logic       exit_valid_i,
    input wire logic       tests_passed_i,
    input wire logic       tests_failed_i,
    input wire logic       debug_req_i,
    input wire dbg_state_e dbg_state_i
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // rvalid mirrors the request of the cycle before
    instr_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rvalid_i == $past(instr_req_i))
        else begin fail_count++; $error("instr_rvalid does not follow instr_req"); end

    data_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rvalid_i == $past(data_req_i))
        else begin fail_count++; $error("data_rvalid does not follow data_req"); end

    // --------------------------------------------------
    // Peripheral outputs
    // --------------------------------------------------

    // Single-cycle pulses
    print_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        print_valid_i |=> !print_valid_i)
        else begin fail_count++; $error("print_valid wider than one cycle"); end

    exit_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exit_valid_i |=> !exit_valid_i)
        else begin fail_count++; $error("exit_valid wider than one cycle"); end

    status_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(tests_passed_i && tests_failed_i))
        else begin fail_count++; $error("tests_passed and tests_failed both high"); end

    // Debug line follows the counter FSM
    debug_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        debug_req_i == (dbg_state_i == DBG_ACTIVE))
        else begin fail_count++; $error("debug_req disagrees with the debug FSM"); end

endmodule

`default_nettype wire

// File: tests/mm_ram_tb.sv
// Memory-mapped RAM testbench
`timescale 1ns/1ps
`default_nettype none

module mm_ram_tb import mm_ram_pkg::*; ();

    localparam int RVALID_TIMEOUT = 16;
    localparam int DEBUG_TIMEOUT  = 300;
    localparam int RANDOM_OPS     = 200;

    // Peripheral event expected after an accepted write
    typedef enum {EV_NONE, EV_PRINT, EV_PASS, EV_FAIL, EV_EXIT, EV_DEBUG} event_e;

    // One row of the directed table
    typedef struct {
        logic                  is_instr;
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [BE_WIDTH-1:0]   be;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] exp_rdata;
        event_e                ev;
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_req;
    logic [ADDR_WIDTH-1:0] instr_addr;
    logic                  instr_gnt;
    logic                  instr_rvalid;
    logic [DATA_WIDTH-1:0] instr_rdata;
    logic                  data_req;
    logic [ADDR_WIDTH-1:0] data_addr;
    logic                  data_we;
    logic [BE_WIDTH-1:0]   data_be;
    logic [DATA_WIDTH-1:0] data_wdata;
    logic                  data_gnt;
    logic                  data_rvalid;
    logic [DATA_WIDTH-1:0] data_rdata;
    logic                  print_valid;
    logic [7:0]            print_char;
    logic                  tests_passed;
    logic                  tests_failed;
    logic                  exit_valid;
    logic [DATA_WIDTH-1:0] exit_value;
    logic                  debug_req;

    // Byte image of the RAM and the last exit code
    logic [7:0]            model_mem [0:RAM_BYTES-1];
    logic [DATA_WIDTH-1:0] exit_expect;
    integer                seed;

    // --------------------------------------------------
    // Directed table: port, we, addr, be, wdata, rdata, event
    // --------------------------------------------------
    entry_t table_q [$] = '{
        // RAM write, byte merge, instruction readback
        '{0, 1, 32'h0000_0100, 4'hf, 32'h1122_3344, 32'h0000_0000, EV_NONE},
        '{0, 0, 32'h0000_0100, 4'hf, 32'h0000_0000, 32'h1122_3344, EV_NONE},
        '{0, 1, 32'h0000_0100, 4'h5, 32'haabb_ccdd, 32'h0000_0000, EV_NONE},
        '{0, 0, 32'h0000_0100, 4'hf, 32'h0000_0000, 32'h11bb_33dd, EV_NONE},
        '{1, 0, 32'h0000_0100, 4'h0, 32'h0000_0000, 32'h11bb_33dd, EV_NONE},
        '{0, 1, 32'h0000_0204, 4'hf, 32'hdead_beef, 32'h0000_0000, EV_NONE},
        '{0, 1, 32'h0000_0204, 4'h8, 32'h7700_0000, 32'h0000_0000, EV_NONE},
        '{1, 0, 32'h0000_0206, 4'h0, 32'h0000_0000, 32'h77ad_beef, EV_NONE},
        // Characters, enables play no part
        '{0, 1, PRINT_ADDR,    4'h1, 32'h0000_0048, 32'h0000_0000, EV_PRINT},
        '{0, 1, PRINT_ADDR,    4'h0, 32'h0000_0169, 32'h0000_0000, EV_PRINT},
        '{0, 1, STATUS_ADDR,   4'hf, PASS_CODE,     32'h0000_0000, EV_PASS},
        '{0, 1, STATUS_ADDR,   4'hf, FAIL_CODE,     32'h0000_0000, EV_FAIL},
        '{0, 1, STATUS_ADDR,   4'hf, 32'h0000_0007, 32'h0000_0000, EV_NONE},
        '{0, 1, EXIT_ADDR,     4'hf, 32'h0000_002a, 32'h0000_0000, EV_EXIT},
        '{0, 1, DEBUG_ADDR,    4'hf, 32'h0000_0005, 32'h0000_0000, EV_DEBUG},
        // Peripheral and unmapped reads
        '{0, 0, PRINT_ADDR,    4'hf, 32'h0000_0000, 32'h0000_0000, EV_NONE},
        '{0, 0, EXIT_ADDR,     4'hf, 32'h0000_0000, 32'h0000_0000, EV_NONE},
        '{0, 0, 32'h0000_1000, 4'hf, 32'h0000_0000, 32'h0000_0000, EV_NONE},
        '{0, 0, 32'h3000_0000, 4'hf, 32'h0000_0000, 32'h0000_0000, EV_NONE},
        // Unmapped writes, one aliasing 0x100 in its low bits
        '{0, 1, 32'h0000_1100, 4'hf, 32'hffff_ffff, 32'h0000_0000, EV_NONE},
        '{0, 1, 32'h4000_0100, 4'hf, 32'h0123_4567, 32'h0000_0000, EV_NONE},
        '{0, 0, 32'h0000_0100, 4'hf, 32'h0000_0000, 32'h11bb_33dd, EV_NONE}
    };

    mm_ram dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_addr_i    (data_addr),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .print_valid_o  (print_valid),
        .print_char_o   (print_char),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value),
        .debug_req_o    (debug_req)
    );

    bind mm_ram mm_ram_assertions mm_ram_assertions_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_req_i    (instr_req_i),
        .instr_rvalid_i (instr_rvalid_o),
        .data_req_i     (data_req_i),
        .data_rvalid_i  (data_rvalid_o),
        .print_valid_i  (print_valid_o),
        .exit_valid_i   (exit_valid_o),
        .tests_passed_i (tests_passed_o),
        .tests_failed_i (tests_failed_o),
        .debug_req_i    (debug_req_o),
        .dbg_state_i    (virt_periph_i.dbg_state_q)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Error reporting and RAM model
    // --------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        report_failure($sformatf("ERR %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    // Bound checker state, watched every cycle
    always @(negedge clk) begin
        assert (dut0.mm_ram_assertions_i.fail_count == 0)
            else report_failure("A bound assertion failed");
    end

    // Initial RAM word, spread over the whole address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [RAM_ADDR_WIDTH-1:0] base;
        base = {addr[RAM_ADDR_WIDTH-1:2], 2'b00};
        return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata);
        logic [RAM_ADDR_WIDTH-1:0] base;
        base = {addr[RAM_ADDR_WIDTH-1:2], 2'b00};
        for (int i = 0; i < BE_WIDTH; i++) begin
            if (be[i]) begin
                model_mem[base + i] = wdata[8*i +: 8];
            end
        end
    endtask

    // --------------------------------------------------
    // Bus access on either or both ports
    // --------------------------------------------------

    // Starts and ends on a falling edge
    task automatic bus_cycle(input logic i_en, input logic [31:0] i_addr,
                             input logic d_en, input logic d_we, input logic [31:0] d_addr,
                             input logic [3:0] d_be, input logic [31:0] d_wdata,
                             output logic [31:0] i_rd, output logic [31:0] d_rd);
        int cycles;
        instr_req  = i_en;
        instr_addr = i_addr;
        data_req   = d_en;
        data_we    = d_we;
        data_addr  = d_addr;
        data_be    = d_be;
        data_wdata = d_wdata;
        #1;
        assert (instr_gnt === instr_req) else report_mismatch("instr_gnt", instr_gnt, instr_req);
        assert (data_gnt === data_req) else report_mismatch("data_gnt", data_gnt, data_req);
        cycles = 0;
        do begin
            @(negedge clk);
            instr_req = 1'b0;
            data_req  = 1'b0;
            cycles++;
        end while (cycles < RVALID_TIMEOUT &&
                   !((instr_rvalid || !i_en) && (data_rvalid || !d_en)));
        assert (cycles < RVALID_TIMEOUT) else report_failure("Timed out waiting for rvalid");
        assert (cycles == 1) else report_failure("rvalid came later than one cycle");
        assert (instr_rvalid === i_en) else report_mismatch("instr_rvalid", instr_rvalid, i_en);
        assert (data_rvalid === d_en) else report_mismatch("data_rvalid", data_rvalid, d_en);
        i_rd = instr_rdata;
        d_rd = data_rdata;
    endtask

    // Counts falling edges with debug_req high
    task automatic measure_debug(input int expected);
        int high_cycles;
        high_cycles = 0;
        while (debug_req === 1'b1 && high_cycles < DEBUG_TIMEOUT) begin
            high_cycles++;
            @(negedge clk);
        end
        assert (high_cycles < DEBUG_TIMEOUT) else report_failure("debug_req never dropped");
        assert (high_cycles == expected)
            else report_mismatch("debug_req cycles", high_cycles, expected);
    endtask

    task automatic check_event(input event_e ev, input logic [31:0] wdata);
        assert (print_valid === (ev == EV_PRINT))
            else report_mismatch("print_valid", print_valid, ev == EV_PRINT);
        assert (tests_passed === (ev == EV_PASS))
            else report_mismatch("tests_passed", tests_passed, ev == EV_PASS);
        assert (tests_failed === (ev == EV_FAIL))
            else report_mismatch("tests_failed", tests_failed, ev == EV_FAIL);
        assert (exit_valid === (ev == EV_EXIT))
            else report_mismatch("exit_valid", exit_valid, ev == EV_EXIT);
        assert (exit_value === exit_expect) else report_mismatch("exit_value", exit_value, exit_expect);
        if (ev == EV_PRINT) begin
            assert (print_char === wdata[7:0])
                else report_mismatch("print_char", print_char, wdata[7:0]);
        end
        if (ev == EV_DEBUG) begin
            measure_debug(wdata[7:0]);
        end else begin
            assert (debug_req === 1'b0) else report_mismatch("debug_req", debug_req, 0);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        logic [DATA_WIDTH-1:0] i_rd;
        logic [DATA_WIDTH-1:0] d_rd;
        logic [DATA_WIDTH-1:0] exp_i;
        logic [DATA_WIDTH-1:0] exp_d;
        logic [DATA_WIDTH-1:0] rnd;
        logic [DATA_WIDTH-1:0] wdata;
        logic [ADDR_WIDTH-1:0] d_addr;
        logic [ADDR_WIDTH-1:0] i_addr;
        logic [ADDR_WIDTH-1:0] prev_addr;
        entry_t                e;

        rst_n       = 1'b0;
        instr_req   = 1'b0;
        instr_addr  = '0;
        data_req    = 1'b0;
        data_addr   = '0;
        data_we     = 1'b0;
        data_be     = '0;
        data_wdata  = '0;
        exit_expect = '0;
        seed        = 32'hcd06d89a;
        prev_addr   = 32'h0000_0100;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Quiet outputs after reset
        check_event(EV_NONE, '0);
        assert (instr_rvalid === 1'b0) else report_mismatch("instr_rvalid", instr_rvalid, 0);
        assert (data_rvalid === 1'b0) else report_mismatch("data_rvalid", data_rvalid, 0);

        // Known contents for every RAM word
        for (int a = 0; a < RAM_BYTES; a += 4) begin
            bus_cycle(1'b0, '0, 1'b1, 1'b1, a, 4'hf, fill_word(a), i_rd, d_rd);
            model_write(a, 4'hf, fill_word(a));
        end

        foreach (table_q[k]) begin
            e = table_q[k];
            if (e.ev == EV_EXIT) begin
                exit_expect = e.wdata;
            end
            bus_cycle(e.is_instr, e.addr, !e.is_instr, e.we, e.addr, e.be, e.wdata, i_rd, d_rd);
            if (e.is_instr) begin
                assert (i_rd === e.exp_rdata) else report_mismatch("instr_rdata", i_rd, e.exp_rdata);
            end else if (!e.we) begin
                assert (d_rd === e.exp_rdata) else report_mismatch("data_rdata", d_rd, e.exp_rdata);
            end else if (e.addr < RAM_BYTES) begin
                model_write(e.addr, e.be, e.wdata);
            end
            check_event(e.ev, e.wdata);
            // Gap cycle, pulses must be gone
            @(negedge clk);
            check_event(EV_NONE, '0);
        end

        // Debug rewrite while active restarts the count
        bus_cycle(1'b0, '0, 1'b1, 1'b1, DEBUG_ADDR, 4'hf, 32'd20, i_rd, d_rd);
        repeat (4) @(negedge clk);
        assert (debug_req === 1'b1) else report_mismatch("debug_req", debug_req, 1);
        bus_cycle(1'b0, '0, 1'b1, 1'b1, DEBUG_ADDR, 4'hf, 32'd6, i_rd, d_rd);
        measure_debug(6);

        // Peripheral and unmapped writes leave every RAM word as the model has it
        for (int a = 0; a < RAM_BYTES; a += 4) begin
            bus_cycle(1'b0, '0, 1'b1, 1'b0, a, 4'hf, '0, i_rd, d_rd);
            exp_d = model_word(a);
            assert (d_rd === exp_d) else report_mismatch("data_rdata", d_rd, exp_d);
        end

        // Random traffic on both ports, back to back
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd    = $random(seed);
            wdata  = $random(seed);
            d_addr = rnd[29] ? prev_addr : {20'h0, rnd[11:2], 2'b00};
            i_addr = rnd[18] ? d_addr : {20'h0, rnd[28:19], 2'b00};
            // Instruction port sees the word before a same-cycle write
            exp_i  = model_word(i_addr);
            exp_d  = model_word(d_addr);
            bus_cycle(rnd[17], i_addr, 1'b1, rnd[12], d_addr, rnd[16:13], wdata, i_rd, d_rd);
            if (rnd[17]) begin
                assert (i_rd === exp_i) else report_mismatch("instr_rdata", i_rd, exp_i);
            end
            if (rnd[12]) begin
                model_write(d_addr, rnd[16:13], wdata);
            end else begin
                assert (d_rd === exp_d) else report_mismatch("data_rdata", d_rd, exp_d);
            end
            prev_addr = d_addr;
        end

        if (dut0.mm_ram_assertions_i.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
design/mm_ram_pkg.sv
design/mem_bus_if.sv
design/dp_ram.sv
design/data_router.sv
design/virt_periph.sv
design/mm_ram.sv
tests/mm_ram_assertions.sv
tests/mm_ram_tb.sv

// File: Bender.yml
package:
  name: mm_ram

sources:
  # Package and interface ahead of the modules that use them
  - target: any(rtl, test)
    files:
      - design/mm_ram_pkg.sv
      - design/mem_bus_if.sv
      - design/dp_ram.sv
      - design/data_router.sv
      - design/virt_periph.sv
      - design/mm_ram.sv

  # Bound assertions before the testbench that binds them
  - target: test
    files:
      - tests/mm_ram_assertions.sv
      - tests/mm_ram_tb.sv
